// File: csr_pkg.sv
package csr_pkg;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    localparam logic [63:0] MSTATUS_RESET = 64'ha00001800; // SXL and UXL fixed at 64 bits.

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    localparam logic [63:0] CAUSE_ILLEGAL_INSTR = 64'd2;
    localparam logic [63:0] CAUSE_ECALL_M       = 64'd11;

    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    localparam logic [2:0] FUNCT3_CSRRW  = 3'b001;
    localparam logic [2:0] FUNCT3_CSRRS  = 3'b010;
    localparam logic [2:0] FUNCT3_CSRRC  = 3'b011;
    localparam logic [2:0] FUNCT3_CSRRWI = 3'b101;
    localparam logic [2:0] FUNCT3_CSRRSI = 3'b110;
    localparam logic [2:0] FUNCT3_CSRRCI = 3'b111;

    localparam logic [31:0] INSTR_ECALL = 32'h00000073;
    localparam logic [31:0] INSTR_MRET  = 32'h30200073;

    typedef enum logic [2:0] {
        CSR_KIND_RW,
        CSR_KIND_RS,
        CSR_KIND_RC,
        CSR_KIND_ECALL,
        CSR_KIND_MRET,
        CSR_KIND_ILLEGAL
    } csr_kind_e;

    typedef struct packed {
        logic [31:0] instr;
        logic [63:0] pc;
        logic [63:0] rs1_data;
    } sys_req_t;

    typedef struct packed {
        csr_kind_e   kind;
        logic [11:0] addr;
        logic [4:0]  rd;
        logic        rd_wen;
        logic        csr_wen;
        logic        use_imm;
        logic [4:0]  zimm;
    } csr_op_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        rd_wen;
        logic [63:0] rd_data;
        logic        redirect;
        logic [63:0] target;
    } sys_rsp_t;

endpackage

// File: csr_decode.sv
`timescale 1ns/1ns

module csr_decode (
    input  logic [31:0]      instr,
    output csr_pkg::csr_op_t op
);

    import csr_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rs1_field;
    logic [4:0] rd_field;
    logic       is_access;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign rs1_field = instr[19:15];
    assign rd_field  = instr[11:7];

    always_comb begin
        is_access  = 1'b0;
        op.kind    = CSR_KIND_ILLEGAL;
        op.addr    = instr[31:20];
        op.rd      = rd_field;
        op.zimm    = rs1_field; // Same bits hold rs1 or the immediate.
        op.use_imm = funct3[2];
        op.csr_wen = 1'b0;

        if (instr == INSTR_ECALL) begin
            op.kind = CSR_KIND_ECALL;
        end else if (instr == INSTR_MRET) begin
            op.kind = CSR_KIND_MRET;
        end else if (opcode == OPCODE_SYSTEM) begin
            case (funct3)
                FUNCT3_CSRRW, FUNCT3_CSRRWI: begin
                    op.kind    = CSR_KIND_RW;
                    op.csr_wen = 1'b1;
                    is_access  = 1'b1;
                end
                FUNCT3_CSRRS, FUNCT3_CSRRSI: begin
                    op.kind    = CSR_KIND_RS;
                    op.csr_wen = (rs1_field != 5'd0); // x0 or zero mask is a pure read.
                    is_access  = 1'b1;
                end
                FUNCT3_CSRRC, FUNCT3_CSRRCI: begin
                    op.kind    = CSR_KIND_RC;
                    op.csr_wen = (rs1_field != 5'd0);
                    is_access  = 1'b1;
                end
                default: begin
                    op.kind = CSR_KIND_ILLEGAL;
                end
            endcase
        end

        op.rd_wen = is_access && (rd_field != 5'd0);
    end

endmodule

// File: csr_file.sv
`timescale 1ns/1ns

module csr_file (
    input  logic        I_sys_clk,
    input  logic        I_rst,
    input  logic        wen,
    input  logic [11:0] wr_addr,
    input  logic [63:0] wr_data,
    input  logic        trap,
    input  logic [63:0] trap_pc,
    input  logic [63:0] trap_cause,
    input  logic        mret,
    input  logic [11:0] rd_addr,
    output logic [63:0] rd_data,
    output logic        addr_valid
);

    import csr_pkg::*;

    logic [63:0] mstatus;
    logic [63:0] mtvec;
    logic [63:0] mepc;
    logic [63:0] mcause;
    logic [63:0] csr_value;

    // Only one of wen, trap and mret is high in any cycle.
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            mstatus <= MSTATUS_RESET;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (wen) begin
            case (wr_addr)
                CSR_MSTATUS: mstatus <= wr_data;
                CSR_MTVEC:   mtvec   <= wr_data;
                CSR_MEPC:    mepc    <= wr_data;
                CSR_MCAUSE:  mcause  <= wr_data;
                default: ;
            endcase
        end else if (trap) begin
            mepc   <= trap_pc;
            mcause <= trap_cause; // mstatus is left as it is on trap entry.
        end else if (mret) begin
            mstatus[MSTATUS_MIE_BIT]  <= mstatus[MSTATUS_MPIE_BIT];
            mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
        end
    end

    always_comb begin
        addr_valid = 1'b1;
        case (rd_addr)
            CSR_MSTATUS: csr_value = mstatus;
            CSR_MTVEC:   csr_value = mtvec;
            CSR_MEPC:    csr_value = mepc;
            CSR_MCAUSE:  csr_value = mcause;
            default: begin
                csr_value  = '0;
                addr_valid = 1'b0;
            end
        endcase
    end

    // Trap and MRET take the read port to supply the redirect target.
    always_comb begin
        if (trap) begin
            rd_data = mtvec;
        end else if (mret) begin
            rd_data = mepc;
        end else begin
            rd_data = csr_value;
        end
    end

endmodule

// File: csr_exec.sv
`timescale 1ns/1ns

module csr_exec (
    input  logic              I_sys_clk,
    input  logic              I_rst,
    input  logic              req_valid,
    input  csr_pkg::sys_req_t req,
    input  csr_pkg::csr_op_t  op,
    output logic              csr_wen,
    output logic [11:0]       csr_wr_addr,
    output logic [63:0]       csr_wr_data,
    output logic              csr_trap,
    output logic [63:0]       csr_trap_pc,
    output logic [63:0]       csr_trap_cause,
    output logic              csr_mret,
    output logic [11:0]       csr_rd_addr,
    input  logic [63:0]       csr_rd_data,
    input  logic              csr_addr_valid,
    output logic              rsp_valid,
    output csr_pkg::sys_rsp_t rsp
);

    import csr_pkg::*;

    logic        is_access;
    logic [63:0] operand;
    logic        redirect_d;
    logic        rd_wen_d;
    logic        redirect_q;
    logic        rd_wen_q;
    logic [4:0]  rd_q;
    logic [63:0] rd_data_q;
    logic [63:0] target_q;

    assign is_access = (op.kind == CSR_KIND_RW) || (op.kind == CSR_KIND_RS) ||
                       (op.kind == CSR_KIND_RC);
    assign operand   = op.use_imm ? {59'd0, op.zimm} : req.rs1_data;

    assign csr_rd_addr = op.addr;
    assign csr_wr_addr = op.addr;

    // An access to an address the CSR file does not hold is illegal.
    assign csr_trap = req_valid && ((op.kind == CSR_KIND_ECALL) ||
                                    (op.kind == CSR_KIND_ILLEGAL) ||
                                    (is_access && !csr_addr_valid));
    assign csr_trap_pc    = req.pc;
    assign csr_trap_cause = (op.kind == CSR_KIND_ECALL) ? CAUSE_ECALL_M : CAUSE_ILLEGAL_INSTR;
    assign csr_mret       = req_valid && (op.kind == CSR_KIND_MRET);
    assign csr_wen        = req_valid && is_access && csr_addr_valid && op.csr_wen;

    always_comb begin
        case (op.kind)
            CSR_KIND_RW: csr_wr_data = operand;
            CSR_KIND_RS: csr_wr_data = csr_rd_data | operand;
            CSR_KIND_RC: csr_wr_data = csr_rd_data & ~operand;
            default:     csr_wr_data = csr_rd_data;
        endcase
    end

    assign redirect_d = csr_trap || csr_mret;
    assign rd_wen_d   = req_valid && is_access && !csr_trap && op.rd_wen;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            rsp_valid  <= 1'b0;
            redirect_q <= 1'b0;
            rd_wen_q   <= 1'b0;
        end else begin
            rsp_valid  <= req_valid;
            redirect_q <= redirect_d;
            rd_wen_q   <= rd_wen_d;
        end
    end

    // The read port holds mtvec on a trap and mepc on MRET.
    always_ff @(posedge I_sys_clk) begin
        if (req_valid) begin
            rd_q      <= op.rd;
            rd_data_q <= rd_wen_d ? csr_rd_data : '0;
            target_q  <= redirect_d ? csr_rd_data : '0;
        end
    end

    assign rsp = '{rd: rd_q, rd_wen: rd_wen_q, rd_data: rd_data_q,
                   redirect: redirect_q, target: target_q};

endmodule

// File: csr_unit.sv
`timescale 1ns/1ns

module csr_unit (
    input  logic              I_sys_clk,
    input  logic              I_rst,
    input  logic              req_valid,
    input  csr_pkg::sys_req_t req,
    output logic              rsp_valid,
    output csr_pkg::sys_rsp_t rsp
);

    import csr_pkg::*;

    csr_op_t     op;
    logic        csr_wen;
    logic [11:0] csr_wr_addr;
    logic [63:0] csr_wr_data;
    logic        csr_trap;
    logic [63:0] csr_trap_pc;
    logic [63:0] csr_trap_cause;
    logic        csr_mret;
    logic [11:0] csr_rd_addr;
    logic [63:0] csr_rd_data;
    logic        csr_addr_valid;

    csr_decode u_csr_decode (
        .instr (req.instr),
        .op    (op)
    );

    csr_exec u_csr_exec (
        .I_sys_clk      (I_sys_clk),
        .I_rst          (I_rst),
        .req_valid      (req_valid),
        .req            (req),
        .op             (op),
        .csr_wen        (csr_wen),
        .csr_wr_addr    (csr_wr_addr),
        .csr_wr_data    (csr_wr_data),
        .csr_trap       (csr_trap),
        .csr_trap_pc    (csr_trap_pc),
        .csr_trap_cause (csr_trap_cause),
        .csr_mret       (csr_mret),
        .csr_rd_addr    (csr_rd_addr),
        .csr_rd_data    (csr_rd_data),
        .csr_addr_valid (csr_addr_valid),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp)
    );

    csr_file u_csr_file (
        .I_sys_clk  (I_sys_clk),
        .I_rst      (I_rst),
        .wen        (csr_wen),
        .wr_addr    (csr_wr_addr),
        .wr_data    (csr_wr_data),
        .trap       (csr_trap),
        .trap_pc    (csr_trap_pc),
        .trap_cause (csr_trap_cause),
        .mret       (csr_mret),
        .rd_addr    (csr_rd_addr),
        .rd_data    (csr_rd_data),
        .addr_valid (csr_addr_valid)
    );

endmodule

// File: tb_csr_unit.sv
`timescale 1ns/1ns

module tb_csr_unit;

    import csr_pkg::*;

    typedef struct packed {
        sys_req_t    req;
        logic        rd_wen;
        logic [63:0] rd_data;
        logic        redirect;
        logic [63:0] target;
    } test_entry_t;

    logic        I_sys_clk = 1'b0;
    logic        I_rst;
    logic        req_valid;
    sys_req_t    req;
    logic        rsp_valid;
    sys_rsp_t    rsp;
    test_entry_t test_q[$];
    string       name_q[$];
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    int          timeout_limit = 0;

    csr_unit u_csr_unit (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    always #2 I_sys_clk = ~I_sys_clk; // 4 ns period.

    function automatic logic [31:0] csr_instr(input logic [2:0] funct3, input logic [11:0] addr,
                                              input logic [4:0] src);
        return {addr, src, funct3, 5'd5, 7'b1110011}; // Old value always goes to x5.
    endfunction

    function automatic logic [31:0] read_csr(input logic [11:0] addr);
        return csr_instr(FUNCT3_CSRRS, addr, 5'd0);
    endfunction

    // A redirecting entry expects no rd write, an access expects the old value in rd.
    task automatic add_test(input string name, input logic [31:0] instr, input logic [63:0] pc,
                            input logic [63:0] rs1_data, input logic [63:0] value,
                            input logic redirect);
        test_entry_t t;
        t.req.instr    = instr;
        t.req.pc       = pc;
        t.req.rs1_data = rs1_data;
        t.rd_wen       = !redirect;
        t.rd_data      = redirect ? 64'h0 : value;
        t.redirect     = redirect;
        t.target       = redirect ? value : 64'h0;
        test_q.push_back(t);
        name_q.push_back(name);
    endtask

    task automatic compare_field(input string name, input string field,
                                 input logic [63:0] expected, input logic [63:0] actual,
                                 inout int errors);
        if (actual !== expected) begin
            $display("mismatch %s %s expected 0x%h actual 0x%h", name, field, expected, actual);
            errors++;
        end
    endtask

    task automatic run_test(input int idx);
        test_entry_t t;
        int          errors;
        t      = test_q[idx];
        errors = 0;
        @(posedge I_sys_clk);
        req_valid <= 1'b1;
        req       <= t.req;
        @(posedge I_sys_clk);
        req_valid <= 1'b0;
        @(negedge I_sys_clk); // Response was registered at the edge that took the request.
        if (rsp_valid !== 1'b1) begin
            $display("%s: no response, rsp_valid was low one cycle after the request",
                     name_q[idx]);
            errors++;
        end else begin
            compare_field(name_q[idx], "rd_wen", t.rd_wen, rsp.rd_wen, errors);
            compare_field(name_q[idx], "redirect", t.redirect, rsp.redirect, errors);
            if (t.rd_wen) begin
                compare_field(name_q[idx], "rd", t.req.instr[11:7], rsp.rd, errors);
                compare_field(name_q[idx], "rd_data", t.rd_data, rsp.rd_data, errors);
            end
            if (t.redirect) begin
                compare_field(name_q[idx], "target", t.target, rsp.target, errors);
            end
        end
        if (errors == 0) begin
            $display("test %s ok", name_q[idx]);
            pass_count++;
        end else begin
            $display("test %s failed with %0d errors", name_q[idx], errors);
            fail_count++;
        end
    endtask

    always @(posedge I_sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        I_rst     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        add_test("reset_mstatus", read_csr(CSR_MSTATUS), 'h100, 'h0, 64'ha00001800, 0);
        add_test("reset_mtvec", read_csr(CSR_MTVEC), 'h100, 'h0, 'h0, 0);
        add_test("reset_mepc", read_csr(CSR_MEPC), 'h100, 'h0, 'h0, 0);
        add_test("reset_mcause", read_csr(CSR_MCAUSE), 'h100, 'h0, 'h0, 0);
        add_test("csrrw_mtvec", csr_instr(FUNCT3_CSRRW, CSR_MTVEC, 5'd6),
                 'h100, 'h80001000, 'h0, 0);
        add_test("csrrs_mtvec", csr_instr(FUNCT3_CSRRS, CSR_MTVEC, 5'd6),
                 'h100, 'hf0, 'h80001000, 0);
        add_test("csrrc_mtvec", csr_instr(FUNCT3_CSRRC, CSR_MTVEC, 5'd6),
                 'h100, 'h30, 'h800010f0, 0);
        add_test("read_mtvec", read_csr(CSR_MTVEC), 'h100, 'h0, 'h800010c0, 0);
        add_test("csrrwi_mcause", csr_instr(FUNCT3_CSRRWI, CSR_MCAUSE, 5'h11),
                 'h100, 'hdead, 'h0, 0);
        add_test("csrrsi_mcause", csr_instr(FUNCT3_CSRRSI, CSR_MCAUSE, 5'h0c),
                 'h100, 'hdead, 'h11, 0);
        add_test("csrrci_mcause", csr_instr(FUNCT3_CSRRCI, CSR_MCAUSE, 5'h05),
                 'h100, 'hdead, 'h1d, 0);
        add_test("read_mcause", read_csr(CSR_MCAUSE), 'h100, 'h0, 'h18, 0);
        add_test("ecall", INSTR_ECALL, 'h2000, 'h0, 'h800010c0, 1);
        add_test("ecall_mepc", read_csr(CSR_MEPC), 'h100, 'h0, 'h2000, 0);
        add_test("ecall_mcause", read_csr(CSR_MCAUSE), 'h100, 'h0, 'd11, 0);
        add_test("set_mie", csr_instr(FUNCT3_CSRRS, CSR_MSTATUS, 5'd6),
                 'h100, 'h8, 64'ha00001800, 0);
        add_test("mret_mpie_low", INSTR_MRET, 'h3000, 'h0, 'h2000, 1);
        add_test("mstatus_after_mret1", read_csr(CSR_MSTATUS), 'h100, 'h0, 64'ha00001880, 0);
        add_test("mret_mpie_high", INSTR_MRET, 'h3004, 'h0, 'h2000, 1);
        add_test("mstatus_after_mret2", read_csr(CSR_MSTATUS), 'h100, 'h0, 64'ha00001888, 0);
        add_test("illegal_csr_addr", read_csr(12'h7c0), 'h4000, 'h0, 'h800010c0, 1);
        add_test("illegal_csr_mcause", read_csr(CSR_MCAUSE), 'h100, 'h0, 'd2, 0);
        add_test("illegal_csr_mepc", read_csr(CSR_MEPC), 'h100, 'h0, 'h4000, 0);
        add_test("non_system_word", 32'h00100093, 'h5000, 'h0, 'h800010c0, 1); // addi x1, x0, 1
        add_test("non_system_mcause", read_csr(CSR_MCAUSE), 'h100, 'h0, 'd2, 0);
        add_test("non_system_mepc", read_csr(CSR_MEPC), 'h100, 'h0, 'h5000, 0);
        timeout_limit = 2 * test_q.size() + 20;
        repeat (3) @(posedge I_sys_clk);
        I_rst <= 1'b0;
        @(negedge I_sys_clk);
        if (rsp_valid !== 1'b0 || rsp.redirect !== 1'b0) begin
            $display("reset_state: rsp_valid or redirect is not low after reset");
            fail_count++;
        end else begin
            $display("test reset_state ok");
            pass_count++;
        end
        foreach (test_q[i]) begin
            run_test(i);
        end
        $display("tests %0d, ok %0d, failed %0d", pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: flist.f
csr_pkg.sv
csr_decode.sv
csr_file.sv
csr_exec.sv
csr_unit.sv
tb_csr_unit.sv

// File: Bender.yml
package:
  name: csr_unit

sources:
  - files:
      - csr_pkg.sv
      - csr_decode.sv
      - csr_file.sv
      - csr_exec.sv
      - csr_unit.sv
  - target: test
    files:
      - tb_csr_unit.sv
